//--- source/sdr_pkg.sv
package sdr_pkg;

    ////////////////////
    // ecpu opcodes
    ////////////////////

    // 4-bit opcode carried in every command word
    typedef enum logic [3:0] {
        NOP        = 4'd0,
        SET_CTRL   = 4'd1,
        GET_CTRL   = 4'd2,
        GET_STATUS = 4'd3,
        GET_CTR0   = 4'd4,
        GET_CTR1   = 4'd5,
        GET_CTR2   = 4'd6,
        GET_CTR3   = 4'd7,
        GET_SRQ    = 4'd8,
        CTR_ENA    = 4'd9,
        CTR_DIS    = 4'd10,
        CTR_CLR    = 4'd11,
        CLR_OVFL   = 4'd12
    } op_e;

    ////////////////////
    // control bits
    ////////////////////

    // bit positions inside the global control register
    localparam int CTRL_OSC_EN    = 0;
    localparam int CTRL_EEPROM_WP = 1;
    localparam int CTRL_SND_INTR  = 2;

    ////////////////////
    // bus words
    ////////////////////

    // command word from the cpu, opcode plus top-of-stack operand
    typedef struct packed {
        op_e         op;
        logic [15:0] tos;
    } cmd_t;

    // decoded stage contents, one strobe per action
    typedef struct packed {
        logic        wr_ctrl;
        logic        clr_ovfl;
        logic        ctr_ena;
        logic        ctr_dis;
        logic        ctr_clr;
        logic        rd;
        // read opcode, NOP when the stage is not a read
        op_e         rd_sel;
        logic [15:0] tos;
    } bus_op_t;

    // status word as the cpu sees it, msb first
    typedef struct packed {
        logic       rx_overflow;
        logic       ctr_ena;
        logic       srq_noted;
        logic       reserved;
        logic [7:0] fpga_ver;
        logic [3:0] fpga_id;
    } status_t;

    // response word, tagged with the read opcode
    typedef struct packed {
        op_e         op;
        logic [15:0] data;
    } rsp_t;

endpackage

//--- source/cmd_ingress.sv
`timescale 1ns/1ps

module cmd_ingress (
    input  logic             cpu_clk,
    input  logic             rx_orst,
    input  sdr_pkg::cmd_t    cmd,
    input  logic             cmd_valid,
    output logic             cmd_ready,
    input  logic             adv,
    output logic             stage_valid,
    output sdr_pkg::bus_op_t bus_op
);

    sdr_pkg::bus_op_t dec;
    logic             accept;

    ////////////////////
    // handshake
    ////////////////////

    // stage can take a new command when empty or leaving this cycle
    assign cmd_ready = !stage_valid || adv;
    assign accept    = cmd_valid && cmd_ready;

    ////////////////////
    // opcode decode
    ////////////////////

    always_comb
    begin
        // unknown opcodes and NOP fall through as an all-zero op
        dec     = '0;
        dec.tos = cmd.tos;
        case (cmd.op)
            sdr_pkg::SET_CTRL: dec.wr_ctrl  = 1'b1;
            sdr_pkg::CLR_OVFL: dec.clr_ovfl = 1'b1;
            sdr_pkg::CTR_ENA:  dec.ctr_ena  = 1'b1;
            sdr_pkg::CTR_DIS:  dec.ctr_dis  = 1'b1;
            sdr_pkg::CTR_CLR:  dec.ctr_clr  = 1'b1;
            sdr_pkg::GET_CTRL, sdr_pkg::GET_STATUS, sdr_pkg::GET_SRQ,
            sdr_pkg::GET_CTR0, sdr_pkg::GET_CTR1, sdr_pkg::GET_CTR2,
            sdr_pkg::GET_CTR3:
            begin
                // reads keep their opcode for the egress mux and the tag
                dec.rd     = 1'b1;
                dec.rd_sel = cmd.op;
            end
            default:
            begin
                dec.rd = 1'b0;
            end
        endcase
    end

    ////////////////////
    // stage register
    ////////////////////

    // occupancy flag
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            stage_valid <= 1'b0;
        else if (accept)
            stage_valid <= 1'b1;
        else if (adv)
            stage_valid <= 1'b0;
    end

    // decoded payload, qualified by stage_valid downstream
    always_ff @(posedge cpu_clk)
    begin
        if (accept)
            bus_op <= dec;
    end

    // a held op never carries two actions at once
    assert property (@(posedge cpu_clk) disable iff (rx_orst)
        stage_valid |-> $onehot0({bus_op.wr_ctrl, bus_op.clr_ovfl, bus_op.ctr_ena,
                                  bus_op.ctr_dis, bus_op.ctr_clr, bus_op.rd}));

endmodule

//--- source/ctrl_status_regs.sv
`timescale 1ns/1ps

module ctrl_status_regs #(
    parameter logic [7:0] FPGA_VER = 8'h5A,
    parameter logic [3:0] FPGA_ID  = 4'h3
) (
    input  logic             cpu_clk,
    input  logic             rx_orst,
    input  sdr_pkg::bus_op_t bus_op,
    input  logic             apply,
    input  logic             adc_ovfl,
    input  logic             host_srq,
    input  logic             ctr_ena,
    output logic [15:0]      ctrl,
    output sdr_pkg::status_t status,
    output logic             srq_noted
);

    logic rx_overflow;
    logic wr_ctrl_go;
    logic clr_ovfl_go;
    logic srq_rd_go;

    ////////////////////
    // strobe qualify
    ////////////////////

    // strobes act only on the edge where the stage retires
    assign wr_ctrl_go  = apply && bus_op.wr_ctrl;
    assign clr_ovfl_go = apply && bus_op.clr_ovfl;

    // a GET_SRQ read also consumes the latched request
    assign srq_rd_go = apply && bus_op.rd && (bus_op.rd_sel == sdr_pkg::GET_SRQ);

    ////////////////////
    // global control
    ////////////////////

    // drives osc enable, eeprom write-protect, sound interrupt
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            ctrl <= '0;
        else if (wr_ctrl_go)
            ctrl <= bus_op.tos;
    end

    ////////////////////
    // sticky overflow
    ////////////////////

    // any overflow pulse is collected until the cpu clears it
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            rx_overflow <= 1'b0;
        else if (clr_ovfl_go)
            // overflow in the clear cycle survives the clear
            rx_overflow <= adc_ovfl;
        else
            rx_overflow <= rx_overflow | adc_ovfl;
    end

    ////////////////////
    // service request
    ////////////////////

    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            srq_noted <= 1'b0;
        else if (srq_rd_go)
            // read hands back the old value, new request stays noted
            srq_noted <= host_srq;
        else
            srq_noted <= srq_noted | host_srq;
    end

    ////////////////////
    // status word
    ////////////////////

    always_comb
    begin
        status             = '0;
        status.rx_overflow = rx_overflow;
        status.ctr_ena     = ctr_ena;
        status.srq_noted   = srq_noted;
        // spare bit always reads zero
        status.reserved    = 1'b0;
        status.fpga_ver    = FPGA_VER;
        status.fpga_id     = FPGA_ID;
    end

    // the flag only drops because a CLR_OVFL retired on that edge
    assert property (@(posedge cpu_clk) disable iff (rx_orst)
        $fell(rx_overflow) |-> $past(clr_ovfl_go));

endmodule

//--- source/cpu_cycle_counters.sv
`timescale 1ns/1ps

module cpu_cycle_counters (
    input  logic             cpu_clk,
    input  logic             rx_orst,
    input  sdr_pkg::bus_op_t bus_op,
    input  logic             apply,
    output logic [31:0]      ctr0,
    output logic [31:0]      ctr1,
    output logic             ctr_ena
);

    logic clr_go;

    // clear event from the retiring stage
    assign clr_go = apply && bus_op.ctr_clr;

    ////////////////////
    // counters
    ////////////////////

    // ctr0 is free running, ctr1 only counts busy cycles
    // load is ctr1 over ctr0 across the same window
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst || clr_go)
        begin
            ctr0 <= '0;
            ctr1 <= '0;
        end
        else
        begin
            ctr0 <= ctr0 + 32'd1;
            ctr1 <= ctr1 + {31'd0, ctr_ena};
        end
    end

    ////////////////////
    // enable
    ////////////////////

    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            ctr_ena <= 1'b0;
        else if (apply && bus_op.ctr_ena)
            ctr_ena <= 1'b1;
        else if (apply && bus_op.ctr_dis)
            ctr_ena <= 1'b0;
    end

    // gated count can never overtake the free-running one
    assert property (@(posedge cpu_clk) disable iff (rx_orst)
        ctr1 <= ctr0);

endmodule

//--- source/read_egress.sv
`timescale 1ns/1ps

module read_egress (
    input  logic             cpu_clk,
    input  logic             rx_orst,
    input  logic             stage_valid,
    input  sdr_pkg::bus_op_t bus_op,
    input  logic [15:0]      ctrl,
    input  sdr_pkg::status_t status,
    input  logic             srq_noted,
    input  logic [31:0]      ctr0,
    input  logic [31:0]      ctr1,
    output logic             adv,
    output sdr_pkg::rsp_t    rsp,
    output logic             rsp_valid,
    input  logic             rsp_ready
);

    logic [15:0] rd_data;
    logic        capture;

    ////////////////////
    // stage advance
    ////////////////////

    // only a read waits, and only while a held response is stalled
    assign adv     = !stage_valid || !bus_op.rd || !rsp_valid || rsp_ready;
    assign capture = stage_valid && bus_op.rd && adv;

    ////////////////////
    // read mux
    ////////////////////

    // counter reads interleave byte k of both counters
    always_comb
    begin
        case (bus_op.rd_sel)
            sdr_pkg::GET_CTRL:   rd_data = ctrl;
            sdr_pkg::GET_STATUS: rd_data = status;
            sdr_pkg::GET_CTR0:   rd_data = {ctr1[7:0], ctr0[7:0]};
            sdr_pkg::GET_CTR1:   rd_data = {ctr1[15:8], ctr0[15:8]};
            sdr_pkg::GET_CTR2:   rd_data = {ctr1[23:16], ctr0[23:16]};
            sdr_pkg::GET_CTR3:   rd_data = {ctr1[31:24], ctr0[31:24]};
            sdr_pkg::GET_SRQ:    rd_data = {15'd0, srq_noted};
            default:             rd_data = '0;
        endcase
    end

    ////////////////////
    // response holding
    ////////////////////

    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            rsp_valid <= 1'b0;
        else if (capture)
            rsp_valid <= 1'b1;
        else if (rsp_ready)
            rsp_valid <= 1'b0;
    end

    // sampled on the same edge the read's strobes apply
    always_ff @(posedge cpu_clk)
    begin
        if (capture)
        begin
            rsp.op   <= bus_op.rd_sel;
            rsp.data <= rd_data;
        end
    end

    // stalled response is held unchanged until taken
    assert property (@(posedge cpu_clk) disable iff (rx_orst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

//--- source/sdr_ctrl_top.sv
`timescale 1ns/1ps

module sdr_ctrl_top #(
    parameter logic [7:0] FPGA_VER = 8'h5A,
    parameter logic [3:0] FPGA_ID  = 4'h3
) (
    input  logic          cpu_clk,
    input  logic          rx_orst,
    input  sdr_pkg::cmd_t cmd,
    input  logic          cmd_valid,
    output logic          cmd_ready,
    output sdr_pkg::rsp_t rsp,
    output logic          rsp_valid,
    input  logic          rsp_ready,
    input  logic          adc_ovfl,
    input  logic          host_srq,
    input  logic          dev_intr,
    output logic          adc_clken,
    output logic          ewp,
    output logic          snd_intr
);

    sdr_pkg::bus_op_t bus_op;
    sdr_pkg::status_t status;
    logic             stage_valid;
    logic             adv;
    logic             apply;
    logic [15:0]      ctrl;
    logic             srq_noted;
    logic [31:0]      ctr0;
    logic [31:0]      ctr1;
    logic             ctr_ena;

    // strobes fire when a held stage retires
    assign apply = stage_valid && adv;

    ////////////////////
    // command side
    ////////////////////

    cmd_ingress u_ingress (
        .cpu_clk     (cpu_clk),
        .rx_orst     (rx_orst),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .adv         (adv),
        .stage_valid (stage_valid),
        .bus_op      (bus_op)
    );

    ////////////////////
    // registers
    ////////////////////

    ctrl_status_regs #(
        .FPGA_VER (FPGA_VER),
        .FPGA_ID  (FPGA_ID)
    ) u_regs (
        .cpu_clk   (cpu_clk),
        .rx_orst   (rx_orst),
        .bus_op    (bus_op),
        .apply     (apply),
        .adc_ovfl  (adc_ovfl),
        .host_srq  (host_srq),
        .ctr_ena   (ctr_ena),
        .ctrl      (ctrl),
        .status    (status),
        .srq_noted (srq_noted)
    );

    cpu_cycle_counters u_ctrs (
        .cpu_clk (cpu_clk),
        .rx_orst (rx_orst),
        .bus_op  (bus_op),
        .apply   (apply),
        .ctr0    (ctr0),
        .ctr1    (ctr1),
        .ctr_ena (ctr_ena)
    );

    ////////////////////
    // response side
    ////////////////////

    read_egress u_egress (
        .cpu_clk     (cpu_clk),
        .rx_orst     (rx_orst),
        .stage_valid (stage_valid),
        .bus_op      (bus_op),
        .ctrl        (ctrl),
        .status      (status),
        .srq_noted   (srq_noted),
        .ctr0        (ctr0),
        .ctr1        (ctr1),
        .adv         (adv),
        .rsp         (rsp),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready)
    );

    ////////////////////
    // board pins
    ////////////////////

    assign adc_clken = ctrl[sdr_pkg::CTRL_OSC_EN];
    assign ewp       = ctrl[sdr_pkg::CTRL_EEPROM_WP];
    // sound interrupt can also come straight from the device
    assign snd_intr  = ctrl[sdr_pkg::CTRL_SND_INTR] | dev_intr;

endmodule

//--- dv/tb_sdr_ctrl.sv
`timescale 1ns/1ps

module tb_sdr_ctrl;

    // non-default ids so the status fields prove the parameters travel down
    localparam logic [7:0] TB_VER     = 8'hA7;
    localparam logic [3:0] TB_ID      = 4'h9;
    localparam int         WAIT_LIMIT = 200;

    // one expected response where mask picks the defined bits
    typedef struct packed {
        sdr_pkg::op_e op;
        logic [15:0]  data;
        logic [15:0]  mask;
        logic         ctr_step;
    } exp_t;

    logic            cpu_clk;
    logic            rx_orst;
    sdr_pkg::cmd_t   cmd;
    logic            cmd_valid;
    logic            cmd_ready;
    sdr_pkg::rsp_t   rsp;
    logic            rsp_valid;
    logic            rsp_ready;
    logic            adc_ovfl;
    logic            host_srq;
    logic            dev_intr;
    logic            adc_clken;
    logic            ewp;
    logic            snd_intr;

    // reference model state, kept in command order
    exp_t            exp_q[$];
    exp_t            head;
    logic            head_ok;
    logic [15:0]     m_ctrl;
    logic            m_ovfl;
    logic            m_srq;
    logic            m_ena;
    logic            m_zero;
    logic            m_prev_rd;
    logic [7:0]      last_b0;

    logic            stall_en;
    logic [31:0]     op_rnd;
    logic [31:0]     rdy_rnd;
    int              errors;
    int              tests;
    int              test_base;

    sdr_ctrl_top #(
        .FPGA_VER (TB_VER),
        .FPGA_ID  (TB_ID)
    ) u_dut (
        .cpu_clk   (cpu_clk),
        .rx_orst   (rx_orst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .adc_ovfl  (adc_ovfl),
        .host_srq  (host_srq),
        .dev_intr  (dev_intr),
        .adc_clken (adc_clken),
        .ewp       (ewp),
        .snd_intr  (snd_intr)
    );

    // 100 ns period
    always #50 cpu_clk = ~cpu_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic void push_exp(input sdr_pkg::op_e op, input logic [15:0] data,
                                     input logic [15:0] mask, input logic ctr_step);
        exp_t e;
        e.op       = op;
        e.data     = data;
        e.mask     = mask;
        e.ctr_step = ctr_step;
        exp_q.push_back(e);
    endfunction

    ////////////////////
    // reference model
    ////////////////////

    task automatic apply_to_model(input sdr_pkg::cmd_t c);
        sdr_pkg::status_t st;
        st             = '0;
        st.rx_overflow = m_ovfl;
        st.ctr_ena     = m_ena;
        st.srq_noted   = m_srq;
        st.fpga_ver    = TB_VER;
        st.fpga_id     = TB_ID;
        case (c.op)
            sdr_pkg::SET_CTRL:   m_ctrl = c.tos;
            sdr_pkg::CLR_OVFL:   m_ovfl = 1'b0;
            sdr_pkg::GET_CTRL:   push_exp(c.op, m_ctrl, 16'hffff, 1'b0);
            sdr_pkg::GET_STATUS: push_exp(c.op, st, 16'hffff, 1'b0);
            sdr_pkg::GET_SRQ:
            begin
                // the read consumes the request
                push_exp(c.op, {15'd0, m_srq}, 16'hffff, 1'b0);
                m_srq = 1'b0;
            end
            sdr_pkg::GET_CTR0:
            begin
                // ctr1 must move between two enabled byte-0 reads
                push_exp(c.op, 16'h0000, m_zero ? 16'hff00 : 16'h0000, m_ena && m_prev_rd);
                m_prev_rd = m_ena;
            end
            sdr_pkg::GET_CTR1, sdr_pkg::GET_CTR2, sdr_pkg::GET_CTR3:
                push_exp(c.op, 16'h0000, m_zero ? 16'hff00 : 16'h0000, 1'b0);
            sdr_pkg::CTR_ENA:
            begin
                m_ena     = 1'b1;
                m_zero    = 1'b0;
                m_prev_rd = 1'b0;
            end
            sdr_pkg::CTR_DIS:
            begin
                m_ena     = 1'b0;
                m_prev_rd = 1'b0;
            end
            sdr_pkg::CTR_CLR:
            begin
                // ctr1 stays at zero only while the enable is off
                m_zero    = !m_ena;
                m_prev_rd = 1'b0;
            end
            default:
            begin
            end
        endcase
    endtask

    always @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            exp_q.delete();
            m_ctrl    = '0;
            m_ovfl    = 1'b0;
            m_srq     = 1'b0;
            m_ena     = 1'b0;
            m_zero    = 1'b1;
            m_prev_rd = 1'b0;
            last_b0   = '0;
        end
        else
        begin
            // a taken response retires the oldest entry
            if (rsp_valid && rsp_ready && exp_q.size() != 0)
            begin
                if (exp_q[0].op == sdr_pkg::GET_CTR0)
                    last_b0 = rsp.data[15:8];
                void'(exp_q.pop_front());
            end
            // pin events land before any command accepted on this edge
            if (adc_ovfl)
                m_ovfl = 1'b1;
            if (host_srq)
                m_srq = 1'b1;
            if (cmd_valid && cmd_ready)
                apply_to_model(cmd);
        end
        head_ok = (exp_q.size() != 0);
        head    = head_ok ? exp_q[0] : '0;
    end

    ////////////////////
    // response checks
    ////////////////////

    a_rsp_expected: assert property (@(posedge cpu_clk) disable iff (rx_orst)
        rsp_valid && rsp_ready |-> head_ok)
    else
    begin
        errors++;
        $display("response taken while no read was outstanding");
    end

    a_rsp_op: assert property (@(posedge cpu_clk) disable iff (rx_orst)
        rsp_valid && rsp_ready && head_ok |-> rsp.op == head.op)
    else
    begin
        errors++;
        $display("Mismatch rsp.op exp %h got %h", $sampled(head.op), $sampled(rsp.op));
    end

    a_rsp_data: assert property (@(posedge cpu_clk) disable iff (rx_orst)
        rsp_valid && rsp_ready && head_ok |-> (rsp.data & head.mask) == (head.data & head.mask))
    else
    begin
        errors++;
        $display("Mismatch rsp.data exp %h got %h (mask %h)",
                 $sampled(head.data), $sampled(rsp.data), $sampled(head.mask));
    end

    a_ctr_step: assert property (@(posedge cpu_clk) disable iff (rx_orst)
        rsp_valid && rsp_ready && head_ok && head.ctr_step |-> rsp.data[15:8] != last_b0)
    else
    begin
        errors++;
        $display("Mismatch rsp.data[15:8] exp not %h got %h", $sampled(last_b0),
                 $sampled(rsp.data[15:8]));
    end

    // stalled response must sit still
    a_rsp_hold: assert property (@(posedge cpu_clk) disable iff (rx_orst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else
    begin
        errors++;
        $display("response changed or dropped while stalled");
    end

    // random back-pressure only while stall_en is set
    always @(posedge cpu_clk)
    begin
        if (stall_en)
        begin
            rdy_rnd = xorshift32(rdy_rnd);
            rsp_ready <= rdy_rnd[3];
        end
        else
            rsp_ready <= 1'b1;
    end

    ////////////////////
    // stimulus tasks
    ////////////////////

    task automatic send_cmd(input sdr_pkg::op_e op, input logic [15:0] tos);
        int waited;
        waited = 0;
        cmd.op    <= op;
        cmd.tos   <= tos;
        cmd_valid <= 1'b1;
        @(posedge cpu_clk);
        while (!cmd_ready && waited < WAIT_LIMIT)
        begin
            @(posedge cpu_clk);
            waited++;
        end
        if (!cmd_ready)
        begin
            errors++;
            $display("Timeout: command %s was never accepted", op.name());
        end
        cmd_valid <= 1'b0;
    endtask

    // wait until every read has been answered and the stage is idle
    task automatic drain_responses;
        int waited;
        waited = 0;
        @(posedge cpu_clk);
        while ((exp_q.size() != 0 || rsp_valid) && waited < WAIT_LIMIT)
        begin
            @(posedge cpu_clk);
            waited++;
        end
        if (waited >= WAIT_LIMIT)
        begin
            errors++;
            $display("Timeout: %0d responses never arrived", exp_q.size());
        end
        repeat (3) @(posedge cpu_clk);
    endtask

    task automatic check_pins;
        logic exp_snd;
        exp_snd = m_ctrl[sdr_pkg::CTRL_SND_INTR] | dev_intr;
        assert (adc_clken == m_ctrl[sdr_pkg::CTRL_OSC_EN])
        else
        begin
            errors++;
            $display("Mismatch adc_clken exp %h got %h", m_ctrl[0], adc_clken);
        end
        assert (ewp == m_ctrl[sdr_pkg::CTRL_EEPROM_WP])
        else
        begin
            errors++;
            $display("Mismatch ewp exp %h got %h", m_ctrl[1], ewp);
        end
        assert (snd_intr == exp_snd)
        else
        begin
            errors++;
            $display("Mismatch snd_intr exp %h got %h", exp_snd, snd_intr);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-10s done, %0d errors", name, errors - test_base);
        test_base = errors;
        tests++;
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial
    begin
        cpu_clk   = 1'b0;
        rx_orst   = 1'b1;
        cmd       = '0;
        cmd_valid = 1'b0;
        rsp_ready = 1'b1;
        adc_ovfl  = 1'b0;
        host_srq  = 1'b0;
        dev_intr  = 1'b0;
        stall_en  = 1'b0;
        op_rnd    = 32'd8;
        rdy_rnd   = 32'd8;
        errors    = 0;
        tests     = 0;
        test_base = 0;
        repeat (4) @(posedge cpu_clk);
        rx_orst <= 1'b0;
        @(posedge cpu_clk);

        // reset state
        assert (!rsp_valid)
        else
        begin
            errors++;
            $display("Mismatch rsp_valid exp %h got %h", 1'b0, rsp_valid);
        end
        check_pins();
        send_cmd(sdr_pkg::GET_CTRL, 16'h0000);
        drain_responses();
        end_test("reset");

        // control register and pins, every pin pattern with and without dev_intr
        for (int i = 0; i < 8; i++)
        begin
            op_rnd = xorshift32(op_rnd);
            send_cmd(sdr_pkg::SET_CTRL, {op_rnd[15:3], i[2:0]});
            send_cmd(sdr_pkg::GET_CTRL, 16'h0000);
            drain_responses();
            check_pins();
            dev_intr <= 1'b1;
            @(posedge cpu_clk);
            check_pins();
            dev_intr <= 1'b0;
            @(posedge cpu_clk);
        end
        end_test("ctrl");

        // sticky overflow from a one-cycle pulse
        adc_ovfl <= 1'b1;
        @(posedge cpu_clk);
        adc_ovfl <= 1'b0;
        @(posedge cpu_clk);
        send_cmd(sdr_pkg::GET_STATUS, 16'h0000);
        repeat (3) @(posedge cpu_clk);
        send_cmd(sdr_pkg::GET_STATUS, 16'h0000);
        send_cmd(sdr_pkg::CLR_OVFL, 16'h0000);
        send_cmd(sdr_pkg::GET_STATUS, 16'h0000);
        drain_responses();
        end_test("overflow");

        // service request is read once then gone
        host_srq <= 1'b1;
        @(posedge cpu_clk);
        host_srq <= 1'b0;
        @(posedge cpu_clk);
        send_cmd(sdr_pkg::GET_SRQ, 16'h0000);
        send_cmd(sdr_pkg::GET_SRQ, 16'h0000);
        drain_responses();
        end_test("srq");

        // counters count while on, then clear while off
        send_cmd(sdr_pkg::CTR_ENA, 16'h0000);
        send_cmd(sdr_pkg::GET_STATUS, 16'h0000);
        repeat (3) send_cmd(sdr_pkg::GET_CTR0, 16'h0000);
        send_cmd(sdr_pkg::CTR_DIS, 16'h0000);
        send_cmd(sdr_pkg::GET_STATUS, 16'h0000);
        send_cmd(sdr_pkg::CTR_CLR, 16'h0000);
        send_cmd(sdr_pkg::GET_CTR0, 16'h0000);
        send_cmd(sdr_pkg::GET_CTR1, 16'h0000);
        send_cmd(sdr_pkg::GET_CTR2, 16'h0000);
        send_cmd(sdr_pkg::GET_CTR3, 16'h0000);
        drain_responses();
        end_test("counters");

        // mixed traffic under random rsp_ready
        stall_en <= 1'b1;
        repeat (48)
        begin
            op_rnd = xorshift32(op_rnd);
            case (op_rnd[18:16] % 7)
                0: send_cmd(sdr_pkg::SET_CTRL, op_rnd[15:0]);
                1: send_cmd(sdr_pkg::GET_CTRL, 16'h0000);
                2: send_cmd(sdr_pkg::GET_STATUS, 16'h0000);
                3: send_cmd(sdr_pkg::GET_SRQ, 16'h0000);
                4: send_cmd(sdr_pkg::GET_CTR2, 16'h0000);
                5: send_cmd(sdr_pkg::CLR_OVFL, 16'h0000);
                default: send_cmd(sdr_pkg::GET_CTRL, 16'h0000);
            endcase
        end
        drain_responses();
        stall_en <= 1'b0;
        drain_responses();
        end_test("backpress");

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- sim.f
source/sdr_pkg.sv
source/cmd_ingress.sv
source/ctrl_status_regs.sv
source/cpu_cycle_counters.sv
source/read_egress.sv
source/sdr_ctrl_top.sv
dv/tb_sdr_ctrl.sv

//--- Bender.yml
package:
  name: sdr_ctrl

sources:
  - files:
      - source/sdr_pkg.sv
      - source/cmd_ingress.sv
      - source/ctrl_status_regs.sv
      - source/cpu_cycle_counters.sv
      - source/read_egress.sv
      - source/sdr_ctrl_top.sv
  - target: simulation
    files:
      - dv/tb_sdr_ctrl.sv
